// ==== common/ldqPkg.sv ====
// Shared widths, counts and load/store record types for the load queue.
// Every block refers to these by scoped name.
package ldqPkg;

  // queue geometry
  localparam int BUF_COUNT = 16;
  localparam int STALL_LEVEL = BUF_COUNT - 2;

  // banks per half of the bank mask
  localparam int BANK_HALF = 16;

  localparam int LINE_W = 20;
  localparam int BANK_W = 2 * BANK_HALF;
  localparam int BLOW_W = 4;
  localparam int II_W = 10;
  localparam int OCC_W = 5;

  typedef logic [LINE_W-1:0] lineAddr_t;
  typedef logic [BANK_W-1:0] banks_t;
  typedef logic [BLOW_W-1:0] blow_t;
  typedef logic [II_W-1:0] ii_t;
  typedef logic [BUF_COUNT-1:0] entryVec_t;
  typedef logic [OCC_W-1:0] occ_t;

  // which line and bank half an access touches
  typedef struct packed {
    logic isOH;
    logic isEH;
    logic isGOR;
    logic isEL;
  } accKind_t;

  // load as held by a queue entry
  typedef struct packed {
    lineAddr_t addrE;
    lineAddr_t addrO;
    banks_t banks;
    blow_t blow;
    accKind_t kind;
    ii_t ii;
    logic thread;
  } ldAccess_t;

  // store address checked against the loads
  typedef struct packed {
    lineAddr_t addrE;
    lineAddr_t addrO;
    banks_t banks;
    blow_t blow;
    accKind_t kind;
  } stCheck_t;

  // retirement of one load
  typedef struct packed {
    ii_t ii;
    logic thread;
  } freeReq_t;

endpackage

// ==== ldq.f ====
common/ldqPkg.sv
verilog/ldqConflict.sv
ldqArray/ldqEntry.sv
ldqArray/ldqArray.sv
verilog/ldqOccupancy.sv
verilog/ldq.sv
test/ldqTb.sv

// ==== ldqArray/ldqArray.sv ====
// The entries of the load queue with first/last free placement.
// New loads get their initial conflict bit from the registered checks.
module ldqArray (
  input logic clk,
  input logic rst,
  input logic except,
  input logic exceptThread,
  input ldqPkg::ldAccess_t new0,
  input ldqPkg::ldAccess_t new1,
  input logic new0En,
  input logic new1En,
  input ldqPkg::stCheck_t chk0,
  input ldqPkg::stCheck_t chk1,
  input logic chkEn0,
  input logic chkEn1,
  input logic aStall,
  input ldqPkg::freeReq_t free0,
  input ldqPkg::freeReq_t free1,
  input logic free0En,
  input logic free1En,
  output logic free0Confl,
  output logic free1Confl
);

  ldqPkg::entryVec_t freeVec;
  ldqPkg::entryVec_t firstFree;
  ldqPkg::entryVec_t lastFree;
  ldqPkg::entryVec_t free0ConflVec;
  ldqPkg::entryVec_t free1ConflVec;
  logic [1:0] new0Chk;
  logic [1:0] new1Chk;
  logic newHit0;
  logic newHit1;

  // port 0 takes the lowest free entry
  assign firstFree = freeVec & (~freeVec + 1'b1);

  // port 1 takes the highest
  always_comb begin
    lastFree = '0;
    for (int i = 0; i < ldqPkg::BUF_COUNT; i++) begin
      if (freeVec[i]) begin
        lastFree = '0;
        lastFree[i] = 1'b1;
      end
    end
  end

  ldqConflict new0Chk0 (
    .ld(new0),
    .chk(chk0),
    .hit(new0Chk[0])
  );

  ldqConflict new0Chk1 (
    .ld(new0),
    .chk(chk1),
    .hit(new0Chk[1])
  );

  ldqConflict new1Chk0 (
    .ld(new1),
    .chk(chk0),
    .hit(new1Chk[0])
  );

  ldqConflict new1Chk1 (
    .ld(new1),
    .chk(chk1),
    .hit(new1Chk[1])
  );

  assign newHit0 = ~aStall & ((new0Chk[0] & chkEn0) | (new0Chk[1] & chkEn1));
  assign newHit1 = ~aStall & ((new1Chk[0] & chkEn0) | (new1Chk[1] & chkEn1));

  for (genvar i = 0; i < ldqPkg::BUF_COUNT; i++) begin : gEntry
    ldqEntry entry (
      .clk(clk),
      .rst(rst),
      .except(except),
      .exceptThread(exceptThread),
      .alloc0(firstFree[i] & new0En),
      .alloc1(lastFree[i] & new1En),
      .new0(new0),
      .new1(new1),
      .newHit0(newHit0),
      .newHit1(newHit1),
      .chk0(chk0),
      .chk1(chk1),
      .chkEn0(chkEn0),
      .chkEn1(chkEn1),
      .aStall(aStall),
      .free0(free0),
      .free1(free1),
      .free0En(free0En),
      .free1En(free1En),
      .free0Confl(free0ConflVec[i]),
      .free1Confl(free1ConflVec[i]),
      .isFree(freeVec[i])
    );
  end

  assign free0Confl = |free0ConflVec;
  assign free1Confl = |free1ConflVec;

endmodule

// ==== ldqArray/ldqEntry.sv ====
// One load queue entry: the load, its conflict bit and its occupied flag.
// Reports a conflict to either free port that names its load.
module ldqEntry (
  input logic clk,
  input logic rst,
  input logic except,
  input logic exceptThread,
  input logic alloc0,
  input logic alloc1,
  input ldqPkg::ldAccess_t new0,
  input ldqPkg::ldAccess_t new1,
  input logic newHit0,
  input logic newHit1,
  input ldqPkg::stCheck_t chk0,
  input ldqPkg::stCheck_t chk1,
  input logic chkEn0,
  input logic chkEn1,
  input logic aStall,
  input ldqPkg::freeReq_t free0,
  input ldqPkg::freeReq_t free1,
  input logic free0En,
  input logic free1En,
  output logic free0Confl,
  output logic free1Confl,
  output logic isFree
);

  ldqPkg::ldAccess_t ld;
  logic occupied;
  logic confl;
  logic hit0;
  logic hit1;
  logic liveHit;
  logic match0;
  logic match1;
  logic flush;
  logic retire;

  ldqConflict conflict0 (
    .ld(ld),
    .chk(chk0),
    .hit(hit0)
  );

  ldqConflict conflict1 (
    .ld(ld),
    .chk(chk1),
    .hit(hit1)
  );

  // live hits only count while the store side is not stalled
  assign liveHit = occupied & ~aStall & ((hit0 & chkEn0) | (hit1 & chkEn1));

  assign match0 = occupied && free0.ii == ld.ii && free0.thread == ld.thread;
  assign match1 = occupied && free1.ii == ld.ii && free1.thread == ld.thread;

  assign flush = except && occupied && ld.thread == exceptThread;
  assign retire = ~aStall & ((free0En & match0) | (free1En & match1));

  assign free0Confl = free0En & match0 & (confl | liveHit);
  assign free1Confl = free1En & match1 & (confl | liveHit);
  assign isFree = ~occupied;

  always_ff @(posedge clk) begin
    if (rst) begin
      occupied <= 1'b0;
      confl <= 1'b0;
    end else if (flush) begin
      occupied <= 1'b0;
      confl <= 1'b0;
    end else if (alloc0) begin
      occupied <= 1'b1;
      confl <= newHit0;
    end else if (alloc1) begin
      occupied <= 1'b1;
      confl <= newHit1;
    end else begin
      if (retire) begin
        occupied <= 1'b0;
      end
      confl <= confl | liveHit;
    end
  end

  // load payload, port 0 wins
  always_ff @(posedge clk) begin
    if (alloc0) begin
      ld <= new0;
    end else if (alloc1) begin
      ld <= new1;
    end
  end

endmodule

// ==== test/ldqTb.sv ====
// Random testbench for the load queue checker, compared against a model of
// the entries, the registered checks and the occupancy counters.
module ldqTb;

  localparam int RESET_CYCLES = 16;
  localparam int IDLE_CYCLES = 20;
  localparam int RANDOM_CYCLES = 2280;
  localparam int FILL_CYCLES = 40;
  localparam int DRAIN_CYCLES = 40;
  localparam int TEST_CYCLES = RESET_CYCLES + 1 + IDLE_CYCLES + RANDOM_CYCLES +
                               FILL_CYCLES + DRAIN_CYCLES;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + 600;

  logic clk;
  logic rst;
  ldqPkg::ldAccess_t new0;
  ldqPkg::ldAccess_t new1;
  logic new0En;
  logic new1En;
  ldqPkg::stCheck_t chk0;
  ldqPkg::stCheck_t chk1;
  logic chk0En;
  logic chk1En;
  ldqPkg::freeReq_t free0;
  ldqPkg::freeReq_t free1;
  logic free0En;
  logic free1En;
  logic stall;
  logic aStall;
  logic except;
  logic exceptThread;
  logic doStall;
  logic free0Confl;
  logic free1Confl;

  // model of the queue as seen after the last edge
  ldqPkg::ldAccess_t mLd [ldqPkg::BUF_COUNT];
  logic mOcc [ldqPkg::BUF_COUNT];
  logic mConfl [ldqPkg::BUF_COUNT];
  ldqPkg::occ_t mCnt [2];
  ldqPkg::stCheck_t mChk0;
  ldqPkg::stCheck_t mChk1;
  logic mChkEn0;
  logic mChkEn1;

  // last flushed load that carried a conflict
  ldqPkg::freeReq_t flushedFree;
  logic haveFlushed;

  logic [31:0] lfsr;
  ldqPkg::ii_t nextIi;
  int errors;
  int checks;
  int cycles;
  logic sawStall;

  ldq i_ldq (
    .clk(clk),
    .rst(rst),
    .new0(new0),
    .new1(new1),
    .new0En(new0En),
    .new1En(new1En),
    .chk0(chk0),
    .chk1(chk1),
    .chk0En(chk0En),
    .chk1En(chk1En),
    .free0(free0),
    .free1(free1),
    .free0En(free0En),
    .free1En(free1En),
    .stall(stall),
    .aStall(aStall),
    .except(except),
    .exceptThread(exceptThread),
    .doStall(doStall),
    .free0Confl(free0Confl),
    .free1Confl(free1Confl)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic conflicts(input ldqPkg::ldAccess_t ld, input ldqPkg::stCheck_t st);
    logic lo;
    logic hi;
    logic lane;
    logic kindMatch;
    lo = 1'b0;
    hi = 1'b0;
    for (int b = 0; b < ldqPkg::BANK_HALF; b++) begin
      lo = lo | (ld.banks[b] & st.banks[b]);
      hi = hi | (ld.banks[b + ldqPkg::BANK_HALF] & st.banks[b + ldqPkg::BANK_HALF]);
    end
    lane = (ld.blow & st.blow) != '0;
    kindMatch = (ld.kind.isOH && st.kind.isOH && ld.addrO == st.addrO && hi) ||
                (ld.kind.isGOR && st.kind.isGOR && ld.addrO == st.addrO && lo) ||
                (ld.kind.isEH && st.kind.isEH && ld.addrE == st.addrE && hi) ||
                (ld.kind.isEL && st.kind.isEL && ld.addrE == st.addrE && lo);
    return lane && kindMatch;
  endfunction

  function automatic logic liveHit(input int i);
    return mOcc[i] && ((mChkEn0 && conflicts(mLd[i], mChk0)) ||
                       (mChkEn1 && conflicts(mLd[i], mChk1)));
  endfunction

  function automatic logic matchesFree(input int i, input ldqPkg::freeReq_t fr);
    return mOcc[i] && mLd[i].ii == fr.ii && mLd[i].thread == fr.thread;
  endfunction

  // next index not held by any entry
  function automatic ldqPkg::ii_t freshIi();
    ldqPkg::ii_t r;
    logic busy;
    busy = 1'b1;
    while (busy) begin
      busy = 1'b0;
      for (int i = 0; i < ldqPkg::BUF_COUNT; i++) begin
        if (mOcc[i] && mLd[i].ii == nextIi) begin
          busy = 1'b1;
        end
      end
      if (busy) begin
        nextIi = nextIi + 1'b1;
      end
    end
    r = nextIi;
    nextIi = nextIi + 1'b1;
    return r;
  endfunction

  // 2-bit addresses and sparse banks so hits and misses both happen
  function automatic ldqPkg::ldAccess_t randomLoad();
    ldqPkg::ldAccess_t ld;
    ld.addrE = ldqPkg::lineAddr_t'(randBits(2));
    ld.addrO = ldqPkg::lineAddr_t'(randBits(2));
    ld.banks = randBits(32) & randBits(32);
    ld.blow = ldqPkg::blow_t'(randBits(4));
    ld.kind = ldqPkg::accKind_t'(randBits(4));
    ld.ii = freshIi();
    ld.thread = randBits(1) != 0;
    return ld;
  endfunction

  function automatic ldqPkg::stCheck_t randomCheck();
    ldqPkg::stCheck_t st;
    st.addrE = ldqPkg::lineAddr_t'(randBits(2));
    st.addrO = ldqPkg::lineAddr_t'(randBits(2));
    st.banks = randBits(32) & randBits(32);
    st.blow = ldqPkg::blow_t'(randBits(4));
    st.kind = ldqPkg::accKind_t'(randBits(4));
    return st;
  endfunction

  function automatic int pickHeld(input int skip);
    int start;
    int idx;
    int pick;
    start = randBits(4);
    pick = -1;
    for (int k = 0; k < ldqPkg::BUF_COUNT; k++) begin
      idx = (start + k) % ldqPkg::BUF_COUNT;
      if (pick < 0 && mOcc[idx] && idx != skip) begin
        pick = idx;
      end
    end
    return pick;
  endfunction

  // mode 0 idle frees under aStall, 1 random, 2 fill, 3 drain
  task automatic driveCycle(input int mode);
    int pick0;
    int pick1;
    ldqPkg::freeReq_t fr0;
    ldqPkg::freeReq_t fr1;
    logic holdFree;
    pick0 = pickHeld(-1);
    pick1 = pickHeld(pick0);
    fr0 = '0;
    fr1 = '0;
    if (pick0 >= 0) begin
      fr0 = {mLd[pick0].ii, mLd[pick0].thread};
    end
    if (pick1 >= 0) begin
      fr1 = {mLd[pick1].ii, mLd[pick1].thread};
    end
    new0 <= randomLoad();
    new1 <= randomLoad();
    chk0 <= randomCheck();
    chk1 <= randomCheck();
    free0 <= fr0;
    free1 <= fr1;
    new0En <= 1'b0;
    new1En <= 1'b0;
    chk0En <= 1'b0;
    chk1En <= 1'b0;
    free0En <= pick0 >= 0;
    free1En <= pick1 >= 0;
    stall <= 1'b0;
    aStall <= 1'b0;
    except <= 1'b0;
    exceptThread <= randBits(1) != 0;
    case (mode)
      0: begin
        free0 <= ldqPkg::freeReq_t'(randBits(11));
        free1 <= ldqPkg::freeReq_t'(randBits(11));
        free0En <= 1'b1;
        free1En <= 1'b1;
        aStall <= 1'b1;
      end
      1: begin
        new0En <= randBits(1) != 0;
        new1En <= randBits(1) != 0;
        chk0En <= randBits(1) != 0;
        chk1En <= randBits(1) != 0;
        free0En <= pick0 >= 0 && randBits(1) != 0;
        free1En <= pick1 >= 0 && randBits(1) != 0;
        stall <= randBits(3) == 0;
        holdFree = randBits(3) == 0;
        aStall <= holdFree;
        except <= randBits(5) == 0;
        // free a flushed load while frees are blocked
        if (holdFree && haveFlushed) begin
          free0 <= flushedFree;
          free0En <= 1'b1;
        end
      end
      2: begin
        new0En <= 1'b1;
        new1En <= 1'b1;
        free0En <= 1'b0;
        free1En <= 1'b0;
      end
      default: begin
      end
    endcase
  endtask

  // compare outputs for the current inputs, then step the model over the next edge
  task automatic checkAndUpdate();
    logic exp0;
    logic exp1;
    logic expStall;
    logic take0;
    logic take1;
    logic hitNew0;
    logic hitNew1;
    logic live;
    int first;
    int last;
    int total;
    total = mCnt[0] + mCnt[1];
    expStall = total >= ldqPkg::STALL_LEVEL;
    exp0 = 1'b0;
    exp1 = 1'b0;
    for (int i = 0; i < ldqPkg::BUF_COUNT; i++) begin
      live = !aStall && liveHit(i);
      if (free0En && matchesFree(i, free0) && (mConfl[i] || live)) begin
        exp0 = 1'b1;
      end
      if (free1En && matchesFree(i, free1) && (mConfl[i] || live)) begin
        exp1 = 1'b1;
      end
    end
    checkValue(doStall, expStall, "doStall");
    checkValue(free0Confl, exp0, "free0Confl");
    checkValue(free1Confl, exp1, "free1Confl");
    if (doStall) begin
      sawStall = 1'b1;
    end

    // loads of the flushed thread are refused too
    take0 = new0En && !stall && !expStall && !(except && new0.thread == exceptThread);
    take1 = new1En && !stall && !expStall && !(except && new1.thread == exceptThread);
    hitNew0 = !aStall && ((mChkEn0 && conflicts(new0, mChk0)) ||
                          (mChkEn1 && conflicts(new0, mChk1)));
    hitNew1 = !aStall && ((mChkEn0 && conflicts(new1, mChk0)) ||
                          (mChkEn1 && conflicts(new1, mChk1)));
    first = -1;
    last = -1;
    for (int i = 0; i < ldqPkg::BUF_COUNT; i++) begin
      if (!mOcc[i]) begin
        if (first < 0) begin
          first = i;
        end
        last = i;
      end
    end
    for (int t = 0; t < 2; t++) begin
      if (take0 && new0.thread == t) begin
        mCnt[t] = mCnt[t] + 1'b1;
      end
      if (take1 && new1.thread == t) begin
        mCnt[t] = mCnt[t] + 1'b1;
      end
      if (free0En && !aStall && free0.thread == t) begin
        mCnt[t] = mCnt[t] - 1'b1;
      end
      if (free1En && !aStall && free1.thread == t) begin
        mCnt[t] = mCnt[t] - 1'b1;
      end
      if (except && exceptThread == t) begin
        mCnt[t] = '0;
      end
    end
    for (int i = 0; i < ldqPkg::BUF_COUNT; i++) begin
      live = !aStall && liveHit(i);
      if (except && mOcc[i] && mLd[i].thread == exceptThread) begin
        if (mConfl[i] || live) begin
          flushedFree = {mLd[i].ii, mLd[i].thread};
          haveFlushed = 1'b1;
        end
        mOcc[i] = 1'b0;
        mConfl[i] = 1'b0;
      end else if (take0 && i == first) begin
        mOcc[i] = 1'b1;
        mConfl[i] = hitNew0;
        mLd[i] = new0;
      end else if (take1 && i == last) begin
        mOcc[i] = 1'b1;
        mConfl[i] = hitNew1;
        mLd[i] = new1;
      end else begin
        if (!aStall && ((free0En && matchesFree(i, free0)) ||
                        (free1En && matchesFree(i, free1)))) begin
          mOcc[i] = 1'b0;
        end
        mConfl[i] = mConfl[i] | live;
      end
    end
    mChk0 = chk0;
    mChk1 = chk1;
    mChkEn0 = chk0En;
    mChkEn1 = chk1En;
  endtask

  task automatic runPhase(input int mode, input int count);
    repeat (count) begin
      @(posedge clk);
      driveCycle(mode);
      @(negedge clk);
      checkAndUpdate();
    end
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles, %0d errors so far",
               TIMEOUT_CYCLES, errors);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    lfsr = 32'hd7744a86;
    nextIi = '0;
    errors = 0;
    checks = 0;
    cycles = 0;
    sawStall = 1'b0;
    flushedFree = '0;
    haveFlushed = 1'b0;
    rst = 1'b1;
    new0 = '0;
    new1 = '0;
    new0En = 1'b0;
    new1En = 1'b0;
    chk0 = '0;
    chk1 = '0;
    chk0En = 1'b0;
    chk1En = 1'b0;
    free0 = '0;
    free1 = '0;
    free0En = 1'b0;
    free1En = 1'b0;
    stall = 1'b0;
    aStall = 1'b0;
    except = 1'b0;
    exceptThread = 1'b0;
    for (int i = 0; i < ldqPkg::BUF_COUNT; i++) begin
      mLd[i] = '0;
      mOcc[i] = 1'b0;
      mConfl[i] = 1'b0;
    end
    mCnt[0] = '0;
    mCnt[1] = '0;
    mChk0 = '0;
    mChk1 = '0;
    mChkEn0 = 1'b0;
    mChkEn1 = 1'b0;

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkAndUpdate();
    runPhase(0, IDLE_CYCLES);
    runPhase(1, RANDOM_CYCLES);
    sawStall = 1'b0;
    runPhase(2, FILL_CYCLES);
    checkValue(sawStall, 1'b1, "doStall raised while filling");
    runPhase(3, DRAIN_CYCLES);
    checkValue(doStall, 1'b0, "doStall after draining");

    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog/ldq.sv ====
// Load queue memory-ordering checker, top level.
// Registers the store checks and qualifies allocation and free strobes.
module ldq (
  input logic clk,
  input logic rst,
  input ldqPkg::ldAccess_t new0,
  input ldqPkg::ldAccess_t new1,
  input logic new0En,
  input logic new1En,
  input ldqPkg::stCheck_t chk0,
  input ldqPkg::stCheck_t chk1,
  input logic chk0En,
  input logic chk1En,
  input ldqPkg::freeReq_t free0,
  input ldqPkg::freeReq_t free1,
  input logic free0En,
  input logic free1En,
  input logic stall,
  input logic aStall,
  input logic except,
  input logic exceptThread,
  output logic doStall,
  output logic free0Confl,
  output logic free1Confl
);

  ldqPkg::stCheck_t chk0Reg;
  ldqPkg::stCheck_t chk1Reg;
  logic chk0EnReg;
  logic chk1EnReg;
  logic new0Take;
  logic new1Take;
  logic free0Take;
  logic free1Take;

  always_ff @(posedge clk) begin
    chk0Reg <= chk0;
    chk1Reg <= chk1;
    if (rst) begin
      chk0EnReg <= 1'b0;
      chk1EnReg <= 1'b0;
    end else begin
      chk0EnReg <= chk0En;
      chk1EnReg <= chk1En;
    end
  end

  // a load of the thread being flushed is dropped
  assign new0Take = new0En & ~stall & ~doStall & ~(except & (new0.thread == exceptThread));
  assign new1Take = new1En & ~stall & ~doStall & ~(except & (new1.thread == exceptThread));

  assign free0Take = free0En & ~aStall;
  assign free1Take = free1En & ~aStall;

  // entries gate retirement with aStall themselves
  ldqArray array (
    .clk(clk),
    .rst(rst),
    .except(except),
    .exceptThread(exceptThread),
    .new0(new0),
    .new1(new1),
    .new0En(new0Take),
    .new1En(new1Take),
    .chk0(chk0Reg),
    .chk1(chk1Reg),
    .chkEn0(chk0EnReg),
    .chkEn1(chk1EnReg),
    .aStall(aStall),
    .free0(free0),
    .free1(free1),
    .free0En(free0En),
    .free1En(free1En),
    .free0Confl(free0Confl),
    .free1Confl(free1Confl)
  );

  ldqOccupancy occupancy (
    .clk(clk),
    .rst(rst),
    .except(except),
    .exceptThread(exceptThread),
    .new0Take(new0Take),
    .new1Take(new1Take),
    .new0Thr(new0.thread),
    .new1Thr(new1.thread),
    .free0Take(free0Take),
    .free1Take(free1Take),
    .free0Thr(free0.thread),
    .free1Thr(free1.thread),
    .doStall(doStall)
  );

endmodule

// ==== verilog/ldqConflict.sv ====
// Overlap test of one load against one store check.
// Purely combinational, shared by the entries and the new-load path.
module ldqConflict (
  input ldqPkg::ldAccess_t ld,
  input ldqPkg::stCheck_t chk,
  output logic hit
);

  logic laneHit;
  logic bankLo;
  logic bankHi;
  logic sameE;
  logic sameO;
  logic kindHit;

  // byte lanes must share a bit
  assign laneHit = |(ld.blow & chk.blow);

  assign bankLo = |(ld.banks[ldqPkg::BANK_HALF-1:0] &
                    chk.banks[ldqPkg::BANK_HALF-1:0]);
  assign bankHi = |(ld.banks[2*ldqPkg::BANK_HALF-1:ldqPkg::BANK_HALF] &
                    chk.banks[2*ldqPkg::BANK_HALF-1:ldqPkg::BANK_HALF]);

  assign sameE = ld.addrE == chk.addrE;
  assign sameO = ld.addrO == chk.addrO;

  // odd line uses addrO, even line uses addrE
  assign kindHit = (ld.kind.isOH & chk.kind.isOH & sameO & bankHi) |
                   (ld.kind.isGOR & chk.kind.isGOR & sameO & bankLo) |
                   (ld.kind.isEH & chk.kind.isEH & sameE & bankHi) |
                   (ld.kind.isEL & chk.kind.isEL & sameE & bankLo);

  assign hit = kindHit & laneHit;

endmodule

// ==== verilog/ldqOccupancy.sv ====
// Per-thread and total load queue occupancy with the stall decision.
// Counts update on the same edge as the allocations and frees they count.
module ldqOccupancy (
  input logic clk,
  input logic rst,
  input logic except,
  input logic exceptThread,
  input logic new0Take,
  input logic new1Take,
  input logic new0Thr,
  input logic new1Thr,
  input logic free0Take,
  input logic free1Take,
  input logic free0Thr,
  input logic free1Thr,
  output logic doStall
);

  ldqPkg::occ_t occ [0:1];
  ldqPkg::occ_t occNext [0:1];
  ldqPkg::occ_t total;

  always_comb begin
    for (int t = 0; t < 2; t++) begin
      occNext[t] = occ[t];
      if (new0Take && new0Thr == t[0]) begin
        occNext[t] = occNext[t] + 1'b1;
      end
      if (new1Take && new1Thr == t[0]) begin
        occNext[t] = occNext[t] + 1'b1;
      end
      if (free0Take && free0Thr == t[0]) begin
        occNext[t] = occNext[t] - 1'b1;
      end
      if (free1Take && free1Thr == t[0]) begin
        occNext[t] = occNext[t] - 1'b1;
      end
      // flushed thread empties
      if (except && exceptThread == t[0]) begin
        occNext[t] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      occ[0] <= '0;
      occ[1] <= '0;
      total <= '0;
    end else begin
      occ[0] <= occNext[0];
      occ[1] <= occNext[1];
      total <= occNext[0] + occNext[1];
    end
  end

  // leave headroom for two loads in flight
  assign doStall = total >= ldqPkg::STALL_LEVEL;

endmodule
